//--- verilog/rv_isa_pkg.sv
// RV32I encodings used by the hart and the testbench reference model
// Import with a wildcard in the module header
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN   = 32;     // Data and address width
    localparam int REG_AW = 5;      // Register index width, 32 architectural regs

    // Major opcodes kept by this core, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,        // R-type arithmetic
        OP_IMM = 7'b0010011,        // I-type arithmetic
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,        // Only lw is used
        STORE  = 7'b0100011,        // Only sw is used
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011         // ebreak
    } opcode_e;

    // Arithmetic funct3, shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,           // add/sub, sub needs funct7[5]
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,           // srl/sra picked by inst[30]
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_alu_e;

    // Branch conditions, 010 and 011 are reserved
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } funct3_br_e;

endpackage

`default_nettype wire

//--- verilog/hart_ctrl_pkg.sv
// Control types passed from decode to execute inside the hart
`default_nettype none

package hart_ctrl_pkg;

    // ALU function, PASS_B forwards operand B untouched
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    // Writeback source for rd
    typedef enum logic [1:0] {
        WB_ALU = 2'b00,             // Arithmetic and lui
        WB_MEM = 2'b01,             // lw
        WB_PC4 = 2'b10              // jal link address
    } wb_sel_e;

    // ALU operand A source
    typedef enum logic {
        OPA_RS1  = 1'b0,
        OPA_ZERO = 1'b1             // lui
    } op_a_sel_e;

endpackage

`default_nettype wire

//--- verilog/hart_fetch.sv
// Program counter with its next-pc mux and the run/halt state
// The pc only advances while running; ebreak stops it until reset
`timescale 1ns/1ns
`default_nettype none

module hart_fetch
    import rv_isa_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  wire             clk,
    input  wire             i_rst,
    input  wire             i_halt,             // ebreak decoded this cycle
    input  wire             i_branch_taken,     // Taken branch or jal
    input  wire [XLEN-1:0]  i_target,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_pc_plus4,
    output logic            o_halted            // Not retiring this cycle
);

    // Halt latch, set by ebreak and cleared only by reset
    typedef enum logic {ST_RUN, ST_HALT} fetch_state_e;

    fetch_state_e    state;
    logic [XLEN-1:0] next_pc;

    assign o_pc_plus4 = o_pc + XLEN'(4);
    assign next_pc    = i_branch_taken ? i_target : o_pc_plus4;
    assign o_halted   = i_rst || (state == ST_HALT);    // Nothing retires in reset

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ST_RUN;
            o_pc  <= RESET_ADDR;
        end else if (state == ST_RUN) begin
            o_pc <= next_pc;                            // Held once halted
            if (i_halt) state <= ST_HALT;               // Latched until reset
        end
    end

    // Targets come from execute, so this checks the immediate path as well
    pc_aligned_a: assert property (@(posedge clk) disable iff (i_rst) o_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/hart_decode.sv
// Instruction decoder: register indices, immediate and control signals
// Purely combinational, driven straight from the imem read data
`timescale 1ns/1ns
`default_nettype none

module hart_decode
    import rv_isa_pkg::*;
    import hart_ctrl_pkg::*;
(
    input  wire [XLEN-1:0]    i_inst,
    output logic [REG_AW-1:0] o_rs1_addr,
    output logic [REG_AW-1:0] o_rs2_addr,
    output logic [REG_AW-1:0] o_rd_addr,
    output logic [XLEN-1:0]   o_imm,
    output alu_op_e           o_alu_op,
    output op_a_sel_e         o_op_a_sel,
    output logic              o_use_imm,      // Operand B is the immediate
    output wb_sel_e           o_wb_sel,
    output logic              o_rd_wen,
    output logic              o_mem_ren,
    output logic              o_mem_wen,
    output logic              o_is_branch,
    output logic              o_is_jal,
    output funct3_br_e        o_br_funct,
    output logic              o_halt
);

    opcode_e         opcode;
    funct3_alu_e     f3;
    alu_op_e         alu_fn;                  // Function for OP / OP_IMM
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode     = opcode_e'(i_inst[6:0]);
    assign f3         = funct3_alu_e'(i_inst[14:12]);
    assign o_br_funct = funct3_br_e'(i_inst[14:12]);
    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];
    assign o_rd_addr  = i_inst[11:7];

    // Immediate formats, all sign extended from inst[31]
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // sub exists only as a register form; inst[30] of addi is immediate data
    // srai carries the same inst[30] flag as sra
    always_comb begin
        case (f3)
            F3_ADD:  alu_fn = (opcode == OP && i_inst[30]) ? SUB : ADD;
            F3_SLL:  alu_fn = SLL;
            F3_SLT:  alu_fn = SLT;
            F3_SLTU: alu_fn = SLTU;
            F3_XOR:  alu_fn = XOR;
            F3_SR:   alu_fn = i_inst[30] ? SRA : SRL;
            F3_OR:   alu_fn = OR;
            default: alu_fn = AND;
        endcase
    end

    always_comb begin
        // Defaults give a no-op that writes nothing
        o_imm       = '0;
        o_alu_op    = ADD;
        o_op_a_sel  = OPA_RS1;
        o_use_imm   = 1'b0;
        o_wb_sel    = WB_ALU;
        o_rd_wen    = 1'b0;
        o_mem_ren   = 1'b0;
        o_mem_wen   = 1'b0;
        o_is_branch = 1'b0;
        o_is_jal    = 1'b0;
        o_halt      = 1'b0;
        case (opcode)
            OP: begin
                o_alu_op = alu_fn;
                o_rd_wen = 1'b1;
            end
            OP_IMM: begin
                o_alu_op  = alu_fn;
                o_imm     = imm_i;
                o_use_imm = 1'b1;
                o_rd_wen  = 1'b1;
            end
            LUI: begin
                o_alu_op   = PASS_B;
                o_op_a_sel = OPA_ZERO;
                o_imm      = imm_u;
                o_use_imm  = 1'b1;
                o_rd_wen   = 1'b1;
            end
            LOAD: begin                       // Address is rs1 + imm through the ALU
                o_imm     = imm_i;
                o_use_imm = 1'b1;
                o_wb_sel  = WB_MEM;
                o_rd_wen  = 1'b1;
                o_mem_ren = 1'b1;
            end
            STORE: begin
                o_imm     = imm_s;
                o_use_imm = 1'b1;
                o_mem_wen = 1'b1;
            end
            BRANCH: begin
                o_imm       = imm_b;
                o_is_branch = 1'b1;
            end
            JAL: begin
                o_imm    = imm_j;
                o_wb_sel = WB_PC4;            // Link address
                o_rd_wen = 1'b1;
                o_is_jal = 1'b1;
            end
            SYSTEM: o_halt = (i_inst[31:20] == 12'h001);  // ebreak only, ecall is a no-op
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/hart_regfile.sv
// Integer register file, two asynchronous read ports and one write port
// x0 has no storage and always reads as zero
`timescale 1ns/1ns
`default_nettype none

module hart_regfile
    import rv_isa_pkg::*;
(
    input  wire              clk,
    input  wire              i_rst,
    input  wire [REG_AW-1:0] i_rs1_addr,
    input  wire [REG_AW-1:0] i_rs2_addr,
    input  wire [REG_AW-1:0] i_rd_addr,
    input  wire              i_rd_wen,
    input  wire [XLEN-1:0]   i_rd_wdata,
    output logic [XLEN-1:0]  o_rs1_data,
    output logic [XLEN-1:0]  o_rs2_data
);

    localparam int NREGS = 2 ** REG_AW;

    logic [XLEN-1:0] regs [1:NREGS-1];      // x1 to x31

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < NREGS; i++) regs[i] <= '0;   // Architectural state starts at zero
        end else if (i_rd_wen && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_wdata;  // Writes to x0 dropped
        end
    end

    // No bypass, a write is seen by the next instruction
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- verilog/hart_execute.sv
// ALU, branch unit, data memory drive and writeback mux
// Combinational; results are consumed by fetch and the register file at the edge
`timescale 1ns/1ns
`default_nettype none

module hart_execute
    import rv_isa_pkg::*;
    import hart_ctrl_pkg::*;
(
    input  wire [XLEN-1:0]  i_pc,
    input  wire [XLEN-1:0]  i_pc_plus4,
    input  wire [XLEN-1:0]  i_rs1_data,
    input  wire [XLEN-1:0]  i_rs2_data,
    input  wire [XLEN-1:0]  i_imm,
    input  wire alu_op_e    i_alu_op,
    input  wire op_a_sel_e  i_op_a_sel,
    input  wire             i_use_imm,
    input  wire wb_sel_e    i_wb_sel,
    input  wire             i_mem_ren,
    input  wire             i_mem_wen,
    input  wire             i_is_branch,
    input  wire             i_is_jal,
    input  wire funct3_br_e i_br_funct,
    input  wire             i_halted,
    input  wire [XLEN-1:0]  i_dmem_rdata,
    output logic            o_branch_taken,
    output logic [XLEN-1:0] o_target,
    output logic [XLEN-1:0] o_dmem_addr,
    output logic            o_dmem_ren,
    output logic            o_dmem_wen,
    output logic [XLEN-1:0] o_dmem_wdata,
    output logic [XLEN-1:0] o_rd_wdata
);

    logic [XLEN-1:0] op_a, op_b, alu_res;
    logic [4:0]      shamt;
    logic            br_eq, br_lt, br_ltu, br_cond;

    assign op_a  = (i_op_a_sel == OPA_ZERO) ? '0 : i_rs1_data;
    assign op_b  = i_use_imm ? i_imm : i_rs2_data;
    assign shamt = op_b[4:0];                       // Upper bits ignored, as RV32I requires

    always_comb begin
        case (i_alu_op)
            ADD:     alu_res = op_a + op_b;         // Also load/store address
            SUB:     alu_res = op_a - op_b;
            SLL:     alu_res = op_a << shamt;
            SLT:     alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:     alu_res = op_a ^ op_b;
            SRL:     alu_res = op_a >> shamt;
            SRA:     alu_res = $signed(op_a) >>> shamt;
            OR:      alu_res = op_a | op_b;
            AND:     alu_res = op_a & op_b;
            PASS_B:  alu_res = op_b;                // lui
            default: alu_res = '0;
        endcase
    end

    // Branch compare always works on rs1/rs2, never on the immediate
    assign br_eq  = (i_rs1_data == i_rs2_data);
    assign br_lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
    assign br_ltu = (i_rs1_data < i_rs2_data);

    always_comb begin
        case (i_br_funct)
            BEQ:     br_cond = br_eq;
            BNE:     br_cond = !br_eq;
            BLT:     br_cond = br_lt;
            BGE:     br_cond = !br_lt;
            BLTU:    br_cond = br_ltu;
            BGEU:    br_cond = !br_ltu;
            default: br_cond = 1'b0;                // Reserved encodings fall through
        endcase
    end

    assign o_branch_taken = i_is_jal || (i_is_branch && br_cond);
    assign o_target       = i_pc + i_imm;           // Shared by branches and jal

    // Word accesses only, so the byte offset is dropped
    assign o_dmem_addr  = {alu_res[XLEN-1:2], 2'b00};
    assign o_dmem_ren   = i_mem_ren && !i_halted;
    assign o_dmem_wen   = i_mem_wen && !i_halted;
    assign o_dmem_wdata = i_rs2_data;

    always_comb begin
        case (i_wb_sel)
            WB_MEM:  o_rd_wdata = i_dmem_rdata;
            WB_PC4:  o_rd_wdata = i_pc_plus4;
            default: o_rd_wdata = alu_res;
        endcase
    end

    // Decode must never mark one opcode as both load and store
    mem_excl_a: assert final (!(o_dmem_ren && o_dmem_wen));

endmodule

`default_nettype wire

//--- verilog/hart_top.sv
// Single-cycle RV32I hart: fetch, decode, register file and execute
// imem and dmem reads are combinational, all state changes land on the clock edge
`timescale 1ns/1ns
`default_nettype none

module hart_top
    import rv_isa_pkg::*;
    import hart_ctrl_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_ADDR = '0     // Must be word aligned
) (
    input  wire               clk,
    input  wire               i_rst,
    output logic [XLEN-1:0]   o_imem_raddr,
    input  wire [XLEN-1:0]    i_imem_rdata,
    output logic [XLEN-1:0]   o_dmem_addr,
    output logic              o_dmem_ren,
    output logic              o_dmem_wen,
    output logic [XLEN-1:0]   o_dmem_wdata,
    input  wire [XLEN-1:0]    i_dmem_rdata,
    output logic              o_retire_valid,
    output logic [XLEN-1:0]   o_retire_inst,
    output logic [XLEN-1:0]   o_retire_pc,
    output logic [XLEN-1:0]   o_retire_next_pc,
    output logic [REG_AW-1:0] o_retire_rd_waddr,
    output logic [XLEN-1:0]   o_retire_rd_wdata,
    output logic              o_retire_halt
);

    logic [XLEN-1:0]   pc, pc_plus4, target, rs1_data, rs2_data, imm, rd_wdata;
    logic [REG_AW-1:0] rs1_addr, rs2_addr, rd_addr;
    logic              halted, halt, branch_taken, rd_wen, rf_wen;
    logic              use_imm, mem_ren, mem_wen, is_branch, is_jal;
    alu_op_e           alu_op;
    op_a_sel_e         op_a_sel;
    wb_sel_e           wb_sel;
    funct3_br_e        br_funct;

    hart_fetch #(.RESET_ADDR(RESET_ADDR)) hart_fetch_i (
        .clk(clk), .i_rst(i_rst), .i_halt(halt), .i_branch_taken(branch_taken),
        .i_target(target), .o_pc(pc), .o_pc_plus4(pc_plus4), .o_halted(halted)
    );

    hart_decode hart_decode_i (
        .i_inst(i_imem_rdata), .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
        .o_rd_addr(rd_addr), .o_imm(imm), .o_alu_op(alu_op), .o_op_a_sel(op_a_sel),
        .o_use_imm(use_imm), .o_wb_sel(wb_sel), .o_rd_wen(rd_wen), .o_mem_ren(mem_ren),
        .o_mem_wen(mem_wen), .o_is_branch(is_branch), .o_is_jal(is_jal),
        .o_br_funct(br_funct), .o_halt(halt)
    );

    assign rf_wen = rd_wen && !halted;              // Nothing commits in reset or after ebreak

    hart_regfile hart_regfile_i (
        .clk(clk), .i_rst(i_rst), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .i_rd_addr(rd_addr), .i_rd_wen(rf_wen), .i_rd_wdata(rd_wdata),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    hart_execute hart_execute_i (
        .i_pc(pc), .i_pc_plus4(pc_plus4), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .i_imm(imm), .i_alu_op(alu_op), .i_op_a_sel(op_a_sel), .i_use_imm(use_imm),
        .i_wb_sel(wb_sel), .i_mem_ren(mem_ren), .i_mem_wen(mem_wen),
        .i_is_branch(is_branch), .i_is_jal(is_jal), .i_br_funct(br_funct),
        .i_halted(halted), .i_dmem_rdata(i_dmem_rdata), .o_branch_taken(branch_taken),
        .o_target(target), .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren),
        .o_dmem_wen(o_dmem_wen), .o_dmem_wdata(o_dmem_wdata), .o_rd_wdata(rd_wdata)
    );

    assign o_imem_raddr = pc;

    // Retire trace, one instruction per running cycle
    assign o_retire_valid    = !halted;
    assign o_retire_inst     = i_imem_rdata;
    assign o_retire_pc       = pc;
    assign o_retire_next_pc  = branch_taken ? target : pc_plus4;   // Same choice fetch loads
    assign o_retire_rd_waddr = rf_wen ? rd_addr : '0;             // Zero when nothing written
    assign o_retire_rd_wdata = rd_wdata;
    assign o_retire_halt     = halt;

    // ebreak must stop retirement from the very next cycle
    halt_stops_a: assert property (@(posedge clk) disable iff (i_rst)
        (o_retire_valid && o_retire_halt) |=> !o_retire_valid);

endmodule

`default_nettype wire

//--- testbench/tb_hart_iss.svh
// Instruction-level RV32I model, included inside tb_hart
// reset_model clears it, step_model retires one instruction and fills the exp_ values
`ifndef TB_HART_ISS_SVH
`define TB_HART_ISS_SVH

logic [XLEN-1:0]   m_regs [0:31];
logic [XLEN-1:0]   m_pc;
logic [XLEN-1:0]   m_mem [0:DMEM_WORDS-1];
logic [XLEN-1:0]   exp_pc, exp_inst, exp_next_pc, exp_wdata, exp_addr, exp_sdata;
logic [REG_AW-1:0] exp_waddr;                   // Zero when no register changes
logic              exp_halt, exp_ren, exp_wen;

function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                             input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: return (a < b) ? 32'd1 : 32'd0;
        3'b100: return a ^ b;
        3'b101: begin
            if (alt) return $signed(a) >>> b[4:0];  // Arithmetic shift keeps the sign
            return a >> b[4:0];
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
    case (funct3_br_e'(f3))
        BEQ:     return a == b;
        BNE:     return a != b;
        BLT:     return $signed(a) < $signed(b);
        BGE:     return $signed(a) >= $signed(b);
        BLTU:    return a < b;
        BGEU:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

task automatic reset_model();
    m_pc = RESET_ADDR;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) m_mem[i] = fill_word(i);
endtask

// x0 never changes and is never reported
task automatic write_rd(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] val);
    if (rd != '0) begin
        m_regs[rd] = val;
        exp_waddr  = rd;
        exp_wdata  = val;
    end
endtask

task automatic step_model(input logic [XLEN-1:0] inst);
    logic [XLEN-1:0]   a, b, imm_i, imm_s, imm_b, imm_j;
    logic [REG_AW-1:0] rd;
    a           = m_regs[inst[19:15]];
    b           = m_regs[inst[24:20]];
    rd          = inst[11:7];
    imm_i       = {{20{inst[31]}}, inst[31:20]};
    imm_s       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b       = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j       = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    exp_pc      = m_pc;
    exp_inst    = inst;
    exp_next_pc = m_pc + 32'd4;                 // Also reported for ebreak
    exp_waddr   = '0;
    exp_wdata   = '0;
    exp_halt    = 1'b0;
    exp_ren     = 1'b0;
    exp_wen     = 1'b0;
    exp_addr    = '0;
    exp_sdata   = '0;
    case (opcode_e'(inst[6:0]))
        OP:     write_rd(rd, alu_model(inst[14:12], inst[30], a, b));
        OP_IMM: write_rd(rd, alu_model(inst[14:12], inst[14:12] == 3'b101 && inst[30],
                                       a, imm_i));  // No subi
        LUI:    write_rd(rd, {inst[31:12], 12'b0});
        LOAD: begin
            exp_ren  = 1'b1;
            exp_addr = a + imm_i;
            write_rd(rd, m_mem[exp_addr[9:2]]);
        end
        STORE: begin
            exp_wen   = 1'b1;
            exp_addr  = a + imm_s;
            exp_sdata = b;
            m_mem[exp_addr[9:2]] = b;
        end
        BRANCH: if (branch_cond(inst[14:12], a, b)) exp_next_pc = m_pc + imm_b;
        JAL: begin
            write_rd(rd, m_pc + 32'd4);         // Link address
            exp_next_pc = m_pc + imm_j;
        end
        SYSTEM: exp_halt = (inst[31:20] == 12'h001);
        default: ;
    endcase
    m_pc = exp_next_pc;
endtask

`endif

//--- testbench/tb_hart.sv
// Testbench for hart_top: builds a random forward-only program and checks every retire
// against the reference model in tb_hart_iss.svh; compile with src.f
`timescale 1ns/1ns
`default_nettype none

module tb_hart
    import rv_isa_pkg::*;
();

    localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_1000;
    localparam int              PROG_WORDS = 64;
    localparam int              DMEM_WORDS = 256;
    localparam logic [31:0]     SEED       = 32'h7beca17e;
    localparam int              STEP_WAIT  = 1;         // Single cycle core, a retire every cycle

    logic              clk, i_rst;
    logic [XLEN-1:0]   imem_raddr, imem_rdata, imem_off;
    logic [XLEN-1:0]   dmem_addr, dmem_wdata, dmem_rdata;
    logic              dmem_ren, dmem_wen;
    logic              retire_valid, retire_halt;
    logic [XLEN-1:0]   retire_inst, retire_pc, retire_next_pc, retire_rd_wdata;
    logic [REG_AW-1:0] retire_rd_waddr;

    logic [XLEN-1:0] prog [0:PROG_WORDS-1];
    logic [XLEN-1:0] dmem [0:DMEM_WORDS-1];
    logic [31:0]     lcg_state;
    int              word_errs, reg_errs, bit_errs, wait_errs;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Initial data memory word, every address bit changes the value
    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return (32'(idx) * 32'h9e3779b9) ^ 32'hc3a5_0f1e;
    endfunction

    `include "tb_hart_iss.svh"

    hart_top #(.RESET_ADDR(RESET_ADDR)) hart_top_i (
        .clk(clk), .i_rst(i_rst), .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
        .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
        .o_dmem_wdata(dmem_wdata), .i_dmem_rdata(dmem_rdata),
        .o_retire_valid(retire_valid), .o_retire_inst(retire_inst), .o_retire_pc(retire_pc),
        .o_retire_next_pc(retire_next_pc), .o_retire_rd_waddr(retire_rd_waddr),
        .o_retire_rd_wdata(retire_rd_wdata), .o_retire_halt(retire_halt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                             // 100 ns period
    end

    // Combinational memories, as the core expects
    assign imem_off   = imem_raddr - RESET_ADDR;
    assign imem_rdata = prog[imem_off[7:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_wen) dmem[dmem_addr[9:2]] <= dmem_wdata;  // Store lands on the edge
    end

    // Forward-only branches and jal, so the run always reaches the final ebreak
    task automatic build_program();
        logic [31:0] r, s;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3, bf3;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        int          tgt;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            r    = lcg_next();
            s    = lcg_next();
            rd   = s[4:0];
            rs1  = s[9:5];
            rs2  = s[14:10];
            f3   = s[17:15];
            bf3  = {f3[2], f3[2] & f3[1], f3[0]};           // Reserved 01x folded onto beq/bne
            tgt  = i + 1 + int'(s[30:20] % (PROG_WORDS - 1 - i));
            boff = 13'((tgt - i) * 4);
            joff = 21'((tgt - i) * 4);
            if (f3 == 3'b001) imm12 = {7'b0, r[4:0]};       // slli
            else if (f3 == 3'b101) imm12 = {1'b0, s[31], 5'b0, r[4:0]};
            else imm12 = r[11:0];
            case (r[31:29])
                3'd0, 3'd1: prog[i] = {1'b0, s[31] & (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                                       rs2, rs1, f3, rd, OP};
                3'd2: prog[i] = {imm12, rs1, f3, rd, OP_IMM};
                3'd3: prog[i] = {r[19:0], rd, LUI};
                3'd4: prog[i] = {2'b0, r[7:0], 2'b00, 5'd0, 3'b010, rd, LOAD};   // lw off(x0)
                3'd5: prog[i] = {2'b0, r[7:3], rs2, 5'd0, 3'b010, r[2:0], 2'b00, STORE};
                3'd6: prog[i] = {boff[12], boff[10:5], rs2, rs1, bf3, boff[4:1], boff[11],
                                 BRANCH};
                default: prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, JAL};
            endcase
        end
        prog[PROG_WORDS-1] = 32'h0010_0073;                 // ebreak
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            word_errs++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_AW-1:0] got,
                             input logic [REG_AW-1:0] exp);
        if (got !== exp) begin
            reg_errs++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errs++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Steps on rising edges until a retire shows up or the limit runs out
    // Values read at the edge are the ones that edge commits
    task automatic wait_retire(input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < limit) begin
            @(posedge clk);
            n++;
            ok = (retire_valid === 1'b1);
        end
        if (!ok) begin
            wait_errs++;
            $display("Timed out after %0d cycles waiting for a retired instruction", limit);
        end
    endtask

    task automatic compare_retire();
        logic [XLEN-1:0] off;
        off = m_pc - RESET_ADDR;
        step_model(prog[off[7:2]]);
        check_word("o_imem_raddr", imem_raddr, exp_pc);
        check_word("o_retire_pc", retire_pc, exp_pc);
        check_word("o_retire_inst", retire_inst, exp_inst);
        check_word("o_retire_next_pc", retire_next_pc, exp_next_pc);
        check_reg("o_retire_rd_waddr", retire_rd_waddr, exp_waddr);
        if (exp_waddr != '0) check_word("o_retire_rd_wdata", retire_rd_wdata, exp_wdata);
        check_bit("o_retire_halt", retire_halt, exp_halt);
        check_bit("o_dmem_ren", dmem_ren, exp_ren);
        check_bit("o_dmem_wen", dmem_wen, exp_wen);
        if (exp_ren || exp_wen) check_word("o_dmem_addr", dmem_addr, exp_addr);
        if (exp_wen) check_word("o_dmem_wdata", dmem_wdata, exp_sdata);
    endtask

    initial begin
        bit ok;
        int retired;
        i_rst     = 1'b1;
        lcg_state = SEED;
        word_errs = 0;
        reg_errs  = 0;
        bit_errs  = 0;
        wait_errs = 0;
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = fill_word(i);
        build_program();
        reset_model();
        repeat (3) begin                                    // Three rising edges in reset
            @(posedge clk);
            check_bit("o_retire_valid", retire_valid, 1'b0);
            check_bit("o_dmem_ren", dmem_ren, 1'b0);
            check_bit("o_dmem_wen", dmem_wen, 1'b0);
        end
        @(negedge clk);
        i_rst   = 1'b0;
        retired = 0;
        wait_retire(STEP_WAIT, ok);
        if (ok) check_word("o_retire_pc", retire_pc, RESET_ADDR);
        while (ok) begin
            compare_retire();
            retired++;
            if (exp_halt) break;
            if (retired >= PROG_WORDS) begin
                wait_errs++;
                $display("Timed out: no ebreak after %0d retired instructions", retired);
                ok = 1'b0;
            end else begin
                wait_retire(STEP_WAIT, ok);
            end
        end
        if (ok) begin
            repeat (10) begin                               // Core must stay halted
                @(posedge clk);
                check_bit("o_retire_valid", retire_valid, 1'b0);
                check_bit("o_dmem_ren", dmem_ren, 1'b0);
                check_bit("o_dmem_wen", dmem_wen, 1'b0);
            end
            for (int i = 1; i < 32; i++) begin
                check_word($sformatf("x%0d", i), hart_top_i.hart_regfile_i.regs[i], m_regs[i]);
            end
            for (int i = 0; i < DMEM_WORDS; i++) begin
                check_word($sformatf("dmem[%0d]", i), dmem[i], m_mem[i]);
            end
        end
        $display("Errors: %0d word, %0d reg, %0d bit, %0d timeout",
                 word_errs, reg_errs, bit_errs, wait_errs);
        if (word_errs + reg_errs + bit_errs + wait_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
verilog/rv_isa_pkg.sv
verilog/hart_ctrl_pkg.sv
verilog/hart_fetch.sv
verilog/hart_decode.sv
verilog/hart_regfile.sv
verilog/hart_execute.sv
verilog/hart_top.sv
testbench/tb_hart.sv

//--- Bender.yml
package:
  name: rv32i_hart

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/hart_ctrl_pkg.sv
      - verilog/hart_fetch.sv
      - verilog/hart_decode.sv
      - verilog/hart_regfile.sv
      - verilog/hart_execute.sv
      - verilog/hart_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_hart.sv
